// ==== src/axi_bridge_defs.svh ====
`ifndef AXI_BRIDGE_DEFS_SVH
`define AXI_BRIDGE_DEFS_SVH

// AXI address and beat widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// a line is one incrementing burst of four beats
`define LINE_BEATS 4
`define LINE_W     128

// id carries the read owner
`define AXI_ID_W   4

// arlen / awlen field
`define AXI_LEN_W  8

`endif

// ==== src/axi_bridge_pkg.sv ====
`include "axi_bridge_defs.svh"

package axi_bridge_pkg;

    // request opcode from a requester port
    typedef enum logic {
        req_word = 1'b0,
        req_line = 1'b1
    } req_type_e;

    // read owner, also sent as arid and returned as rid
    typedef enum logic [`AXI_ID_W-1:0] {
        src_inst = `AXI_ID_W'(0),
        src_data = `AXI_ID_W'(1)
    } rd_src_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_e;

    typedef logic [`AXI_DATA_W-1:0] word_t;

    // beat 0 sits in bits [31:0]
    typedef logic [`LINE_W-1:0] line_t;

endpackage

// ==== src/rd_arbiter.sv ====
`include "axi_bridge_defs.svh"

module rd_arbiter
    import axi_bridge_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst_n,

    input  logic                   inst_rd_req,
    input  req_type_e              inst_rd_type,
    input  logic [`AXI_ADDR_W-1:0] inst_rd_addr,
    output logic                   inst_rd_rdy,

    input  logic                   data_rd_req,
    input  req_type_e              data_rd_type,
    input  logic [`AXI_ADDR_W-1:0] data_rd_addr,
    output logic                   data_rd_rdy,

    output rd_src_e                arid,
    output logic [`AXI_ADDR_W-1:0] araddr,
    output logic [`AXI_LEN_W-1:0]  arlen,
    output logic                   arvalid,
    input  logic                   arready,

    input  logic                   inst_done,
    input  logic                   data_done,
    input  logic                   wr_busy
);

    logic ar_idle;
    logic inst_busy;
    logic data_busy;
    logic inst_grant;
    logic data_grant;

    // single AR slot, new grant only once it has drained
    assign ar_idle = !arvalid;

    // data read waits for the write in flight so it sees the new bytes
    assign data_rd_rdy = ar_idle && !data_busy && !wr_busy;
    assign data_grant  = data_rd_req && data_rd_rdy;

    // data has priority over instruction
    assign inst_rd_rdy = ar_idle && !inst_busy && !data_grant;
    assign inst_grant  = inst_rd_req && inst_rd_rdy;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid   <= 1'b0;
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end else if (data_grant || inst_grant) begin
                arvalid <= 1'b1;
            end

            // busy until the collector hands the data back
            if (data_grant) begin
                data_busy <= 1'b1;
            end else if (data_done) begin
                data_busy <= 1'b0;
            end

            if (inst_grant) begin
                inst_busy <= 1'b1;
            end else if (inst_done) begin
                inst_busy <= 1'b0;
            end
        end
    end

    // AR payload, stable while arvalid is high
    always_ff @(posedge aclk) begin
        if (data_grant) begin
            arid   <= src_data;
            araddr <= data_rd_addr;
            arlen  <= (data_rd_type == req_line) ? `AXI_LEN_W'(`LINE_BEATS - 1) : '0;
        end else if (inst_grant) begin
            arid   <= src_inst;
            araddr <= inst_rd_addr;
            arlen  <= (inst_rd_type == req_line) ? `AXI_LEN_W'(`LINE_BEATS - 1) : '0;
        end
    end

endmodule

// ==== src/rd_collector.sv ====
`include "axi_bridge_defs.svh"

module rd_collector
    import axi_bridge_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,

    input  rd_src_e rid,
    input  word_t   rdata,
    input  logic    rlast,
    input  logic    rvalid,
    output logic    rready,

    output logic    inst_ret_valid,
    output line_t   inst_ret_data,
    output logic    data_ret_valid,
    output line_t   data_ret_data,

    output logic    inst_done,
    output logic    data_done
);

    localparam int BEAT_W   = $clog2(`LINE_BEATS);
    localparam int NUM_SRC  = 2;
    localparam int IDX_INST = 0;
    localparam int IDX_DATA = 1;

    logic                beat_ok;
    logic [NUM_SRC-1:0]  beat_hit;
    logic [NUM_SRC-1:0]  ret_q;
    logic [BEAT_W-1:0]   beat_cnt [NUM_SRC];
    line_t               line_buf [NUM_SRC];

    assign beat_ok = rvalid && rready;

    // route each beat by its id, beats of the two sources may interleave
    assign beat_hit[IDX_INST] = beat_ok && (rid == src_inst);
    assign beat_hit[IDX_DATA] = beat_ok && (rid == src_data);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rready <= 1'b0;
            ret_q  <= '0;
            for (int s = 0; s < NUM_SRC; s++) begin
                beat_cnt[s] <= '0;
            end
        end else begin
            // no back-pressure on R
            rready <= 1'b1;
            for (int s = 0; s < NUM_SRC; s++) begin
                ret_q[s] <= beat_hit[s] && rlast;
                if (beat_hit[s]) begin
                    beat_cnt[s] <= rlast ? '0 : beat_cnt[s] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int s = 0; s < NUM_SRC; s++) begin
            if (beat_hit[s]) begin
                // first beat clears the rest, a word read keeps upper words zero
                if (beat_cnt[s] == '0) begin
                    line_buf[s] <= {{(`LINE_W - `AXI_DATA_W){1'b0}}, rdata};
                end else begin
                    line_buf[s][beat_cnt[s]*`AXI_DATA_W +: `AXI_DATA_W] <= rdata;
                end
            end
        end
    end

    assign inst_ret_valid = ret_q[IDX_INST];
    assign inst_ret_data  = line_buf[IDX_INST];
    assign data_ret_valid = ret_q[IDX_DATA];
    assign data_ret_data  = line_buf[IDX_DATA];

    // frees the source slot in the arbiter
    assign inst_done = ret_q[IDX_INST];
    assign data_done = ret_q[IDX_DATA];

endmodule

// ==== src/wr_channel.sv ====
`include "axi_bridge_defs.svh"

module wr_channel
    import axi_bridge_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic                     data_wr_req,
    input  req_type_e                data_wr_type,
    input  logic [`AXI_ADDR_W-1:0]   data_wr_addr,
    input  logic [`AXI_DATA_W/8-1:0] data_wr_wstrb,
    input  line_t                    data_wr_data,
    output logic                     data_wr_rdy,
    output logic                     data_wr_ok,

    output logic [`AXI_ADDR_W-1:0]   awaddr,
    output logic [`AXI_LEN_W-1:0]    awlen,
    output logic                     awvalid,
    input  logic                     awready,

    output word_t                    wdata,
    output logic [`AXI_DATA_W/8-1:0] wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,

    input  logic                     bvalid,
    output logic                     bready,

    output logic                     wr_busy
);

    localparam int BEAT_W = $clog2(`LINE_BEATS);
    localparam int STRB_W = `AXI_DATA_W / 8;

    wr_state_e         state;
    line_t             line_q;
    logic [STRB_W-1:0] strb_q;
    logic [BEAT_W-1:0] beat_cnt;
    logic              wr_accept;

    assign data_wr_rdy = (state == wr_idle);
    assign wr_accept   = data_wr_req && data_wr_rdy;

    // channel valids follow the state
    assign awvalid = (state == wr_addr);
    assign wvalid  = (state == wr_data);
    assign bready  = (state == wr_resp);

    assign wdata = line_q[beat_cnt*`AXI_DATA_W +: `AXI_DATA_W];
    assign wstrb = strb_q;
    assign wlast = (beat_cnt == awlen[BEAT_W-1:0]);

    // also covers the accept cycle so a read requested alongside waits
    assign wr_busy = !data_wr_rdy || wr_accept;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= wr_idle;
            beat_cnt   <= '0;
            data_wr_ok <= 1'b0;
        end else begin
            data_wr_ok <= bvalid && bready;
            case (state)
                wr_idle: begin
                    if (wr_accept) begin
                        state    <= wr_addr;
                        beat_cnt <= '0;
                    end
                end
                wr_addr: begin
                    // W beats only after the address is taken
                    if (awready) begin
                        state <= wr_data;
                    end
                end
                wr_data: begin
                    if (wready) begin
                        if (wlast) begin
                            state <= wr_resp;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                wr_resp: begin
                    if (bvalid) begin
                        state <= wr_idle;
                    end
                end
                default: begin
                    state <= wr_idle;
                end
            endcase
        end
    end

    // captured request, held until the response
    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            awaddr <= data_wr_addr;
            line_q <= data_wr_data;
            if (data_wr_type == req_line) begin
                awlen  <= `AXI_LEN_W'(`LINE_BEATS - 1);
                strb_q <= '1;
            end else begin
                awlen  <= '0;
                strb_q <= data_wr_wstrb;
            end
        end
    end

endmodule

// ==== src/axi_bridge_top.sv ====
`include "axi_bridge_defs.svh"

module axi_bridge_top
    import axi_bridge_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,

    // instruction refill read port
    input  logic                     inst_rd_req,
    input  req_type_e                inst_rd_type,
    input  logic [`AXI_ADDR_W-1:0]   inst_rd_addr,
    output logic                     inst_rd_rdy,
    output logic                     inst_ret_valid,
    output line_t                    inst_ret_data,

    // data port, read side
    input  logic                     data_rd_req,
    input  req_type_e                data_rd_type,
    input  logic [`AXI_ADDR_W-1:0]   data_rd_addr,
    output logic                     data_rd_rdy,
    output logic                     data_ret_valid,
    output line_t                    data_ret_data,

    // data port, write side
    input  logic                     data_wr_req,
    input  req_type_e                data_wr_type,
    input  logic [`AXI_ADDR_W-1:0]   data_wr_addr,
    input  logic [`AXI_DATA_W/8-1:0] data_wr_wstrb,
    input  line_t                    data_wr_data,
    output logic                     data_wr_rdy,
    output logic                     data_wr_ok,

    // AXI master
    output rd_src_e                  arid,
    output logic [`AXI_ADDR_W-1:0]   araddr,
    output logic [`AXI_LEN_W-1:0]    arlen,
    output logic                     arvalid,
    input  logic                     arready,

    input  rd_src_e                  rid,
    input  word_t                    rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,

    output logic [`AXI_ADDR_W-1:0]   awaddr,
    output logic [`AXI_LEN_W-1:0]    awlen,
    output logic                     awvalid,
    input  logic                     awready,

    output word_t                    wdata,
    output logic [`AXI_DATA_W/8-1:0] wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,

    input  logic                     bvalid,
    output logic                     bready
);

    // return done pulses back to the arbiter
    logic inst_done;
    logic data_done;

    // write ordering hold for data reads
    logic wr_busy;

    rd_arbiter u_rd_arbiter (.*);

    rd_collector u_rd_collector (.*);

    wr_channel u_wr_channel (.*);

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 10
) (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // release just after an edge so it never coincides with one
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge aclk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== test/tb_axi_bridge.sv ====
`include "axi_bridge_defs.svh"

module tb_axi_bridge
    import axi_bridge_pkg::*;
();

    localparam int    TIMEOUT    = 400;
    localparam string TRACE_FILE = "test/axi_bridge_trace.txt";
    // unwritten words read as word address xor this
    localparam word_t FILL_PAT   = 32'h5A5A_0000;

    logic aclk;
    logic rst_n;

    logic                     inst_rd_req;
    req_type_e                inst_rd_type;
    logic [`AXI_ADDR_W-1:0]   inst_rd_addr;
    logic                     inst_rd_rdy;
    logic                     inst_ret_valid;
    line_t                    inst_ret_data;
    logic                     data_rd_req;
    req_type_e                data_rd_type;
    logic [`AXI_ADDR_W-1:0]   data_rd_addr;
    logic                     data_rd_rdy;
    logic                     data_ret_valid;
    line_t                    data_ret_data;
    logic                     data_wr_req;
    req_type_e                data_wr_type;
    logic [`AXI_ADDR_W-1:0]   data_wr_addr;
    logic [`AXI_DATA_W/8-1:0] data_wr_wstrb;
    line_t                    data_wr_data;
    logic                     data_wr_rdy;
    logic                     data_wr_ok;

    rd_src_e                  arid;
    logic [`AXI_ADDR_W-1:0]   araddr;
    logic [`AXI_LEN_W-1:0]    arlen;
    logic                     arvalid;
    logic                     arready;
    rd_src_e                  rid;
    word_t                    rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     rready;
    logic [`AXI_ADDR_W-1:0]   awaddr;
    logic [`AXI_LEN_W-1:0]    awlen;
    logic                     awvalid;
    logic                     awready;
    word_t                    wdata;
    logic [`AXI_DATA_W/8-1:0] wstrb;
    logic                     wlast;
    logic                     wvalid;
    logic                     wready;
    logic                     bvalid;
    logic                     bready;

    // per source request, index 0 inst and 1 data
    req_type_e              rd_type [2];
    logic [`AXI_ADDR_W-1:0] rd_addr [2];
    line_t                  rd_exp [2];
    logic [`AXI_LEN_W-1:0]  exp_arlen [2];
    logic [`AXI_LEN_W-1:0]  exp_awlen;
    int                     ret_cnt [2] = '{0, 0};
    line_t                  ret_line [2];
    int                     wr_sent = 0;
    int                     wr_done = 0;

    // slave model state
    rd_src_e                ar_id_q [$];
    logic [`AXI_ADDR_W-1:0] ar_addr_q [$];
    logic [`AXI_LEN_W-1:0]  ar_len_q [$];
    rd_src_e                ar_log [$];
    word_t                  mem [int];
    logic [15:0]            lfsr_q = 16'd14167;

    tb_clock_gen #(.PERIOD(4), .RST_CYCLES(10)) u_clock (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    axi_bridge_top DUT (.*);

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic fail_now(input string what);
        $display("FAIL at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_src(input string name, input rd_src_e got, input rd_src_e exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input logic [`AXI_LEN_W-1:0] got,
                             input logic [`AXI_LEN_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // galois lfsr, one step per stall bit
    function automatic logic rand_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    function automatic word_t read_word(input int widx);
        if (mem.exists(widx)) begin
            return mem[widx];
        end
        return word_t'(widx) ^ FILL_PAT;
    endfunction

    // returns and write responses, sampled mid-cycle
    always @(negedge aclk) begin
        if (inst_ret_valid) begin
            ret_line[0] = inst_ret_data;
            ret_cnt[0]  = ret_cnt[0] + 1;
        end
        if (data_ret_valid) begin
            ret_line[1] = data_ret_data;
            ret_cnt[1]  = ret_cnt[1] + 1;
        end
        if (data_wr_ok) begin
            wr_done = wr_done + 1;
        end
    end

    // AXI slave memory: handshakes seen at the negedge take effect on the next edge
    initial begin : slave_model
        logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
        rd_src_e arid_s;
        logic [`AXI_ADDR_W-1:0] araddr_s, awaddr_s, aw_base;
        logic [`AXI_LEN_W-1:0] arlen_s, awlen_s, aw_len, r_beat, w_beat;
        word_t wdata_s, wv;
        logic [`AXI_DATA_W/8-1:0] wstrb_s;
        logic wlast_s;
        int widx;
        arready = 1'b0;
        rid     = src_inst;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        r_beat  = '0;
        w_beat  = '0;
        aw_base = '0;
        aw_len  = '0;
        forever begin
            @(negedge aclk);
            ar_hs    = arvalid && arready;
            r_hs     = rvalid && rready;
            aw_hs    = awvalid && awready;
            w_hs     = wvalid && wready;
            b_hs     = bvalid && bready;
            arid_s   = arid;
            araddr_s = araddr;
            arlen_s  = arlen;
            awaddr_s = awaddr;
            awlen_s  = awlen;
            wdata_s  = wdata;
            wstrb_s  = wstrb;
            wlast_s  = wlast;
            @(posedge aclk);
            #1;
            if (ar_hs) begin
                check_len("arlen", arlen_s, exp_arlen[arid_s == src_data]);
                ar_id_q.push_back(arid_s);
                ar_addr_q.push_back(araddr_s);
                ar_len_q.push_back(arlen_s);
                ar_log.push_back(arid_s);
            end
            if (aw_hs) begin
                check_len("awlen", awlen_s, exp_awlen);
                aw_base = awaddr_s;
                aw_len  = awlen_s;
                w_beat  = '0;
            end
            if (w_hs) begin
                widx = int'(aw_base >> 2) + int'(w_beat);
                wv   = read_word(widx);
                for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
                    if (wstrb_s[b]) begin
                        wv[b*8 +: 8] = wdata_s[b*8 +: 8];
                    end
                end
                mem[widx] = wv;
                if (wlast_s !== (w_beat == aw_len)) begin
                    fail_now("wlast does not mark the final write beat");
                end
                w_beat = w_beat + 1'b1;
                bvalid = bvalid || wlast_s;
            end
            if (b_hs) begin
                bvalid = 1'b0;
            end
            if (r_hs) begin
                if (rlast) begin
                    void'(ar_id_q.pop_front());
                    void'(ar_addr_q.pop_front());
                    void'(ar_len_q.pop_front());
                    r_beat = '0;
                end else begin
                    r_beat = r_beat + 1'b1;
                end
            end
            // a raised rvalid holds until its handshake
            if (!(rvalid && !r_hs)) begin
                if (ar_id_q.size() > 0) begin
                    rvalid = rand_bit();
                    rid    = ar_id_q[0];
                    rdata  = read_word(int'(ar_addr_q[0] >> 2) + int'(r_beat));
                    rlast  = (r_beat == ar_len_q[0]);
                end else begin
                    rvalid = 1'b0;
                end
            end
            arready = rand_bit();
            awready = rand_bit();
            wready  = rand_bit();
        end
    end

    // mask bit 0 inst, bit 1 data
    task automatic do_reads(input logic [1:0] mask);
        logic [1:0] left;
        logic [1:0] taken;
        int base [2];
        int t;
        string nm;
        base[0] = ret_cnt[0];
        base[1] = ret_cnt[1];
        for (int k = 0; k < 2; k++) begin
            exp_arlen[k] = (rd_type[k] == req_line) ? 8'd3 : 8'd0;
        end
        inst_rd_type = rd_type[0];
        inst_rd_addr = rd_addr[0];
        data_rd_type = rd_type[1];
        data_rd_addr = rd_addr[1];
        inst_rd_req  = mask[0];
        data_rd_req  = mask[1];
        left = mask;
        t = 0;
        while (left != 2'b00) begin
            @(negedge aclk);
            taken = left & {data_rd_rdy, inst_rd_rdy};
            @(posedge aclk);
            #1;
            if (taken[1] && (wr_sent != wr_done)) begin
                fail_now("data read accepted before the earlier write got its response");
            end
            if (taken[0]) begin
                inst_rd_req = 1'b0;
            end
            if (taken[1]) begin
                data_rd_req = 1'b0;
            end
            left = left & ~taken;
            t++;
            if (left != 2'b00 && t > TIMEOUT) begin
                fail_now("read request was never accepted");
            end
        end
        t = 0;
        while ((mask[0] && ret_cnt[0] == base[0]) || (mask[1] && ret_cnt[1] == base[1])) begin
            @(posedge aclk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                fail_now("read data never returned");
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (mask[k]) begin
                nm = (k == 1) ? "data_ret_data" : "inst_ret_data";
                if (rd_type[k] == req_word) begin
                    check_word(nm, ret_line[k][`AXI_DATA_W-1:0], rd_exp[k][`AXI_DATA_W-1:0]);
                end
                check_line(nm, ret_line[k], rd_exp[k]);
            end
        end
    endtask

    task automatic do_write(input req_type_e typ, input logic [`AXI_ADDR_W-1:0] addr,
                            input logic [`AXI_DATA_W/8-1:0] strb, input line_t data);
        logic taken;
        int t;
        exp_awlen     = (typ == req_line) ? 8'd3 : 8'd0;
        data_wr_req   = 1'b1;
        data_wr_type  = typ;
        data_wr_addr  = addr;
        data_wr_wstrb = strb;
        data_wr_data  = data;
        taken = 1'b0;
        t = 0;
        while (!taken) begin
            @(negedge aclk);
            taken = data_wr_rdy;
            @(posedge aclk);
            #1;
            t++;
            if (!taken && t > TIMEOUT) begin
                fail_now("write request was never accepted");
            end
        end
        data_wr_req = 1'b0;
        wr_sent++;
    endtask

    initial begin : trace_replay
        int fd;
        int n;
        int n0;
        int t;
        string line_s;
        logic [3:0] op, src_f, type_f;
        logic [`AXI_DATA_W/8-1:0] strb_f;
        logic [`AXI_ADDR_W-1:0] addr_f;
        line_t data_f, exp_f;
        logic s;
        logic [1:0] staged;
        inst_rd_req   = 1'b0;
        inst_rd_type  = req_word;
        inst_rd_addr  = '0;
        data_rd_req   = 1'b0;
        data_rd_type  = req_word;
        data_rd_addr  = '0;
        data_wr_req   = 1'b0;
        data_wr_type  = req_word;
        data_wr_addr  = '0;
        data_wr_wstrb = '0;
        data_wr_data  = '0;
        staged = 2'b00;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_now("cannot open the trace file");
        end
        t = 0;
        while (rst_n !== 1'b1) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) begin
                fail_now("reset was never released");
            end
        end
        @(posedge aclk);
        #1;
        while (!$feof(fd)) begin
            line_s = "";
            n = $fgets(line_s, fd);
            if (n == 0 || line_s.len() < 2 || line_s.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line_s, "%h %h %h %h %h %h %h",
                        op, src_f, type_f, addr_f, strb_f, data_f, exp_f);
            if (n != 7) begin
                fail_now("malformed line in the trace file");
            end
            s = src_f[0];
            rd_type[s] = type_f[0] ? req_line : req_word;
            rd_addr[s] = addr_f;
            rd_exp[s]  = exp_f;
            case (op)
                4'd0: do_reads(s ? 2'b10 : 2'b01);
                4'd1: do_write(rd_type[s], addr_f, strb_f, data_f);
                4'd2: staged[s] = 1'b1;
                4'd3: begin
                    n0 = ar_log.size();
                    do_reads(staged | (s ? 2'b10 : 2'b01));
                    staged = 2'b00;
                    if (ar_log.size() <= n0) begin
                        fail_now("no AR handshake seen for the paired reads");
                    end
                    // data wins when both ask in the same cycle
                    check_src("arid", ar_log[n0], src_data);
                end
                default: fail_now("unknown operation in the trace file");
            endcase
        end
        $fclose(fd);
        t = 0;
        while (wr_done != wr_sent) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) begin
                fail_now("write response never arrived");
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== axi_bridge.f ====
+incdir+src
src/axi_bridge_pkg.sv
src/rd_arbiter.sv
src/rd_collector.sv
src/wr_channel.sv
src/axi_bridge_top.sv
test/tb_clock_gen.sv
test/tb_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f axi_bridge.f --top-module tb_axi_bridge \
    && ./obj_dir/Vtb_axi_bridge > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/axi_bridge_trace.txt ====
# op: 0 read, 1 write, 2 stage a read, 3 read issued together with the staged one
# op src(0 inst, 1 data) type(0 word, 1 line) addr strb data expected_line (hex)
0 0 1 00000100 0 0 5A5A00435A5A00425A5A00415A5A0040
0 1 0 00000208 0 0 0000000000000000000000005A5A0082
1 1 0 00000300 5 11223344 0
0 1 0 00000300 0 0 0000000000000000000000005A220044
1 1 0 00000304 A AABBCCDD 0
0 1 0 00000304 0 0 000000000000000000000000AA5ACCC1
1 1 1 00000400 F 0123456789ABCDEFFEDCBA9876543210 0
0 1 1 00000400 0 0 0123456789ABCDEFFEDCBA9876543210
0 0 1 00000400 0 0 0123456789ABCDEFFEDCBA9876543210
2 1 1 00000500 0 0 5A5A01435A5A01425A5A01415A5A0140
3 0 1 00000600 0 0 5A5A01835A5A01825A5A01815A5A0180
2 1 0 00000404 0 0 000000000000000000000000FEDCBA98
3 0 0 00000010 0 0 0000000000000000000000005A5A0004
0 1 1 00000300 0 0 5A5A00C35A5A00C2AA5ACCC15A220044
0 0 0 000003FC 0 0 0000000000000000000000005A5A00FF
1 1 0 00000408 3 0000BEEF 0
0 1 1 00000400 0 0 0123456789ABBEEFFEDCBA9876543210
0 0 1 00000400 0 0 0123456789ABBEEFFEDCBA9876543210
